//--- sim.f
hdl/cw_pkg.sv
hdl/cw_config_regs.sv
hdl/cw_timing_calc.sv
hdl/cw_paddle_input.sv
hdl/cw_iambic_keyer.sv
hdl/cw_keyer_top.sv
tests/cw_keyer_sva.sv
tests/tb_cw_keyer.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cw_keyer
FILELIST = sim.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- tests/tb_cw_keyer.sv
`timescale 1ns/10ps

module tb_cw_keyer import cw_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int SPEED      = 60;
  localparam int MS_T       = 48;                        // ticks per ms
  localparam int DOT_T      = 57600 / SPEED;
  localparam int DASH_T     = 3 * DOT_T * 50 / 50;
  localparam int DASH66_T   = 3 * DOT_T * 66 / 50;
  localparam int TEST_TICKS = (4 * MS_T + 100)           // straight key
                            + 2 * (2 * DOT_T + 50)       // dot tap and swap
                            + (DASH66_T + DOT_T + 50)    // weight 66 dash
                            + (5 * DOT_T + DASH_T)       // mode A squeeze
                            + (6 * DOT_T + 2 * DASH_T)   // mode B squeeze
                            + 12 * DOT_T                 // letter spacing
                            + 8 * 20;                    // config writes
  localparam int WATCHDOG_NS = TEST_TICKS * TICK_DIV * CLK_PERIOD * 2;

  logic    clk;
  logic    rst;
  cw_cmd_t cmd;
  logic    dot_key;
  logic    dash_key;
  logic    cw_ptt;
  logic    cw_keydown;
  logic    kd_prev;
  int      cyc;
  int      rise_q[$];   // cycle of each cw_keydown rise
  int      fall_q[$];

  cw_keyer_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .cmd        (cmd),
    .dot_key    (dot_key),
    .dash_key   (dash_key),
    .cw_ptt     (cw_ptt),
    .cw_keydown (cw_keydown)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // records keydown edges for pulse width and gap checks
  always @(posedge clk) begin
    if (rst) begin
      kd_prev <= 1'b0;
    end else begin
      if (cw_keydown && !kd_prev) rise_q.push_back(cyc);
      if (!cw_keydown && kd_prev) fall_q.push_back(cyc);
      kd_prev <= cw_keydown;
    end
    cyc <= cyc + 1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic write_cmd(input logic [5:0] cmd_addr, input logic [31:0] cmd_data);
    @(posedge clk);
    cmd <= '{addr: cmd_addr, data: cmd_data, rqst: 1'b1};
    @(posedge clk);
    cmd.rqst <= 1'b0;
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      0:       return cw_ptt;
      1:       return cw_keydown;
      default: return i_dut.timing.valid;
    endcase
  endfunction

  // polls at the falling edge, where DUT outputs are stable
  task automatic wait_for(input string what, input int sel, input logic level, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (probe(sel) !== level) begin
      if (n == limit) abort_run({"timeout waiting for ", what});
      n++;
      @(negedge clk);
    end
  endtask

  task automatic wait_pulses(input int count, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (rise_q.size() < count) begin
      if (n == limit) abort_run("timeout waiting for keyer elements");
      n++;
      @(negedge clk);
    end
  endtask

  task automatic set_keyer(input logic rev, input logic [1:0] mode, input int weight,
                           input logic spacing);
    logic [31:0] w;
    w        = '0;
    w[22]    = rev;
    w[15:14] = mode;          // 00 straight, 01 A, 10 B
    w[13:8]  = 6'(SPEED);
    w[7]     = spacing;
    w[6:0]   = 7'(weight);
    write_cmd(ADDR_KEYER, w);
    repeat (2) @(posedge clk);  // valid drops after recalc
    wait_for("timing valid", 2, 1'b1, 200);
  endtask

  task automatic set_keys(input logic dot, input logic dash);
    @(posedge clk);
    dot_key  <= dot;
    dash_key <= dash;
  endtask

  task automatic tap_and_measure(input logic dot, input logic dash, input int exp_ticks,
                                 input string name);
    int n0;
    n0 = rise_q.size();
    set_keys(dot, dash);
    wait_for("cw_keydown high", 1, 1'b1, 16 * TICK_DIV);
    set_keys(1'b0, 1'b0);
    wait_for("cw_ptt low", 0, 1'b0, (exp_ticks + 2 * DOT_T + 16) * TICK_DIV);
    check_val({name, " pulse count"}, 32'(rise_q.size() - n0), 32'd1);
    check_val({name, " width"}, 32'(fall_q[n0] - rise_q[n0]), 32'(exp_ticks * TICK_DIV));
  endtask

  task automatic test_straight();
    int t_ptt;
    int t_key;
    int t_up;
    int t_drop;
    write_cmd(ADDR_HANG, 32'h0001_0000);       // hang 1 ms
    write_cmd(ADDR_PTT_DELAY, 32'h0000_0100);  // delay 1 ms
    set_keyer(1'b0, 2'b00, 50, 1'b0);
    set_keys(1'b1, 1'b0);
    wait_for("cw_ptt high", 0, 1'b1, 8 * TICK_DIV);
    t_ptt = cyc;
    wait_for("cw_keydown high", 1, 1'b1, (MS_T + 8) * TICK_DIV);
    t_key = cyc;
    check_val("cw_keydown after ptt delay", 32'(t_key - t_ptt >= MS_T * TICK_DIV), 32'd1);
    repeat (20 * TICK_DIV) @(posedge clk);
    set_keys(1'b0, 1'b0);
    wait_for("cw_keydown low", 1, 1'b0, 8 * TICK_DIV);
    t_up = cyc;
    wait_for("cw_ptt low", 0, 1'b0, (MS_T + 8) * TICK_DIV);
    t_drop = cyc;
    check_val("cw_ptt hang time in range", 32'((t_drop - t_up >= MS_T * TICK_DIV) &&
              (t_drop - t_up <= (MS_T + 4) * TICK_DIV)), 32'd1);
  endtask

  task automatic test_dot_timing();
    set_keyer(1'b0, 2'b01, 50, 1'b0);
    tap_and_measure(1'b1, 1'b0, DOT_T, "mode A dot");
  endtask

  task automatic test_weight();
    set_keyer(1'b0, 2'b01, 66, 1'b0);                 // forces a recompute
    tap_and_measure(1'b0, 1'b1, DASH66_T, "weight 66 dash");
  endtask

  task automatic test_squeeze(input logic [1:0] mode, input string name);
    int n0;
    int exp_n;
    int exp_w[4];
    set_keyer(1'b0, mode, 50, 1'b0);
    exp_w = '{DOT_T, DASH_T, DOT_T, DASH_T};
    exp_n = (mode == 2'b10) ? 4 : 3;                  // mode B adds one opposite element
    n0 = rise_q.size();
    set_keys(1'b1, 1'b1);
    wait_pulses(n0 + 3, (3 * DOT_T + DASH_T + 32) * TICK_DIV);
    repeat (DOT_T * TICK_DIV / 2) @(posedge clk);    // middle of the third dot
    set_keys(1'b0, 1'b0);
    wait_for("cw_ptt low", 0, 1'b0, (DASH_T + 4 * DOT_T + 32) * TICK_DIV);
    check_val({name, " element count"}, 32'(rise_q.size() - n0), 32'(exp_n));
    for (int i = 0; i < exp_n; i++) begin
      check_val($sformatf("%s element %0d width", name, i),
                32'(fall_q[n0 + i] - rise_q[n0 + i]), 32'(exp_w[i] * TICK_DIV));
    end
  endtask

  task automatic test_swap();
    set_keyer(1'b1, 2'b01, 50, 1'b0);
    tap_and_measure(1'b0, 1'b1, DOT_T, "swapped dash key");
  endtask

  task automatic test_spacing();
    int n0;
    set_keyer(1'b0, 2'b01, 50, 1'b1);
    n0 = rise_q.size();
    set_keys(1'b1, 1'b0);
    wait_for("cw_keydown high", 1, 1'b1, 16 * TICK_DIV);
    set_keys(1'b0, 1'b0);
    wait_for("cw_keydown low", 1, 1'b0, (DOT_T + 8) * TICK_DIV);
    repeat (DOT_T * TICK_DIV * 3 / 2) @(posedge clk);  // inside the letter space
    set_keys(1'b1, 1'b0);
    wait_for("cw_keydown high", 1, 1'b1, (2 * DOT_T + 16) * TICK_DIV);
    set_keys(1'b0, 1'b0);
    wait_for("cw_ptt low", 0, 1'b0, (4 * DOT_T + 16) * TICK_DIV);
    check_val("spaced pulse count", 32'(rise_q.size() - n0), 32'd2);
    check_val("letter gap >= 3 dots",
              32'(rise_q[n0 + 1] - fall_q[n0] >= 3 * DOT_T * TICK_DIV), 32'd1);
    set_keyer(1'b0, 2'b01, 50, 1'b0);
    n0 = rise_q.size();
    set_keys(1'b1, 1'b0);                             // held through both dots
    wait_pulses(n0 + 2, (3 * DOT_T + 32) * TICK_DIV);
    set_keys(1'b0, 1'b0);
    wait_for("cw_ptt low", 0, 1'b0, (3 * DOT_T + 16) * TICK_DIV);
    check_val("element gap", 32'(rise_q[n0 + 1] - fall_q[n0]), 32'(DOT_T * TICK_DIV));
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    rst      = 1'b1;
    cmd      = '0;
    dot_key  = 1'b0;
    dash_key = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_straight();
    write_cmd(ADDR_HANG, 32'd0);
    write_cmd(ADDR_PTT_DELAY, 32'd0);
    test_dot_timing();
    test_weight();
    test_squeeze(2'b01, "mode A squeeze");
    test_squeeze(2'b10, "mode B squeeze");
    test_swap();
    test_spacing();
    $display("Test OK");
    $finish;
  end

endmodule

//--- tests/cw_keyer_sva.sv
`timescale 1ns/10ps

module cw_keyer_sva import cw_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       tick,
  input logic       cw_ptt,
  input logic       cw_keydown,
  input cw_timing_t timing
);

  // carrier only while the transmitter is keyed
  a_keydown_ptt: assert property (@(posedge clk) disable iff (rst) cw_keydown |-> cw_ptt)
    else $error("cw_keydown high while cw_ptt is low");

  a_keydown_valid: assert property (@(posedge clk) disable iff (rst)
    $rose(cw_keydown) |-> timing.valid)
    else $error("cw_keydown rose without valid timing");

  a_tick_period: assert property (@(posedge clk) disable iff (rst)
    tick |=> (!tick) [*TICK_DIV-1] ##1 tick)
    else $error("tick is not one cycle in every TICK_DIV");

endmodule

bind cw_iambic_keyer cw_keyer_sva i_keyer_sva (
  .clk        (clk),
  .rst        (rst),
  .tick       (tick),
  .cw_ptt     (cw_ptt),
  .cw_keydown (cw_keydown),
  .timing     (timing)
);

//--- hdl/cw_keyer_top.sv
`timescale 1ns/10ps

module cw_keyer_top import cw_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  cw_cmd_t cmd,
  input  logic    dot_key,
  input  logic    dash_key,
  output logic    cw_ptt,
  output logic    cw_keydown
);

  cw_cfg_t    cfg;
  cw_timing_t timing;
  paddle_t    paddles;
  logic       recalc;
  logic       tick;       // from the keyer tick divider

  cw_config_regs i_config_regs (
    .clk    (clk),
    .rst    (rst),
    .cmd    (cmd),
    .cfg    (cfg),
    .recalc (recalc)
  );

  cw_timing_calc i_timing_calc (
    .clk    (clk),
    .rst    (rst),
    .recalc (recalc),
    .speed  (cfg.speed),
    .weight (cfg.weight),
    .timing (timing)
  );

  cw_paddle_input i_paddle_input (
    .clk      (clk),
    .rst      (rst),
    .tick     (tick),
    .dot_key  (dot_key),
    .dash_key (dash_key),
    .reverse  (cfg.reverse),
    .paddles  (paddles)
  );

  cw_iambic_keyer i_iambic_keyer (
    .clk        (clk),
    .rst        (rst),
    .cfg        (cfg),
    .timing     (timing),
    .paddles    (paddles),
    .tick       (tick),
    .cw_ptt     (cw_ptt),
    .cw_keydown (cw_keydown)
  );

endmodule

//--- hdl/cw_iambic_keyer.sv
`timescale 1ns/10ps

module cw_iambic_keyer import cw_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  cw_cfg_t    cfg,
  input  cw_timing_t timing,
  input  paddle_t    paddles,
  output logic       tick,
  output logic       cw_ptt,
  output logic       cw_keydown
);

  logic [TICK_CNT_W-1:0] tick_cnt;
  keyer_state_e          state;
  logic [17:0]           dur_cnt;     // element and space length in ticks
  logic [15:0]           dot_len;     // dot length latched at element start
  logic [13:0]           delay_cnt;
  logic [15:0]           hang_cnt;
  logic [15:0]           hang_load;
  logic                  dot_mem;
  logic                  dash_mem;
  logic                  last_dash;
  logic                  want_dot;
  logic                  want_dash;
  logic                  pick_dot;
  logic                  pick_dash;
  logic                  want_any;
  logic                  press_any;
  logic                  set_dot_mem;
  logic                  set_dash_mem;
  logic                  elem_go;
  logic                  start_elem;

  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end else begin
      tick     <= (tick_cnt == TICK_LAST);
      tick_cnt <= (tick_cnt == TICK_LAST) ? '0 : tick_cnt + 1'b1;
    end
  end

  assign want_dot  = paddles.dot | dot_mem;
  assign want_dash = paddles.dash | dash_mem;
  assign press_any = paddles.dot | paddles.dash;
  assign hang_load = {6'b0, cfg.hang_ms} * {10'b0, TICKS_PER_MS};

  // mode A only remembers a tap, not a squeeze
  assign set_dash_mem = paddles.dash & ((cfg.mode == MODE_B) | ~paddles.dot);
  assign set_dot_mem  = paddles.dot & ((cfg.mode == MODE_B) | ~paddles.dash);

  always_comb begin
    if (cfg.mode == MODE_STRAIGHT) begin
      pick_dot  = paddles.dot;           // straight key on the dot contact
      pick_dash = 1'b0;
    end else begin
      // squeeze alternates, a new sequence starts with a dot
      pick_dot  = want_dot & (~want_dash | last_dash |
                              (state == ST_PTT_WAIT) | (state == ST_HANG));
      pick_dash = want_dash & ~pick_dot;
    end
  end

  assign want_any = pick_dot | pick_dash;

  // states where the next element may begin on this tick
  always_comb begin
    case (state)
      ST_PTT_WAIT:                    elem_go = (delay_cnt == 14'd0);
      ST_ELEM_SPACE, ST_LETTER_SPACE: elem_go = (dur_cnt <= 18'd1);
      ST_HANG:                        elem_go = 1'b1;
      default:                        elem_go = 1'b0;
    endcase
  end

  assign start_elem = elem_go & want_any & timing.valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      cw_ptt     <= 1'b0;
      cw_keydown <= 1'b0;
      dur_cnt    <= 18'd0;
      delay_cnt  <= 14'd0;
      hang_cnt   <= 16'd0;
      dot_mem    <= 1'b0;
      dash_mem   <= 1'b0;
      last_dash  <= 1'b0;
    end else if (tick) begin
      if (start_elem) begin
        cw_keydown <= 1'b1;
        dot_len    <= timing.dot_ticks;
        if (pick_dot) begin
          state     <= ST_DOT;
          dur_cnt   <= {2'b0, timing.dot_ticks};
          dot_mem   <= 1'b0;
          last_dash <= 1'b0;
        end else begin
          state     <= ST_DASH;
          dur_cnt   <= timing.dash_ticks;
          dash_mem  <= 1'b0;
          last_dash <= 1'b1;
        end
      end else begin
        case (state)
          ST_IDLE: begin
            if (press_any && timing.valid) begin
              cw_ptt    <= 1'b1;
              delay_cnt <= {6'b0, cfg.ptt_delay_ms} * {8'b0, TICKS_PER_MS};
              state     <= ST_PTT_WAIT;
            end
          end
          ST_PTT_WAIT: begin
            if (delay_cnt != 14'd0) begin
              delay_cnt <= delay_cnt - 14'd1;
            end else begin
              state    <= ST_HANG;       // paddle let go during the delay
              hang_cnt <= hang_load;
            end
          end
          ST_DOT: begin
            if (cfg.mode == MODE_STRAIGHT) begin
              if (!paddles.dot) begin
                cw_keydown <= 1'b0;
                state      <= ST_HANG;
                hang_cnt   <= hang_load;
              end
            end else begin
              if (set_dash_mem) dash_mem <= 1'b1;
              if (dur_cnt <= 18'd1) begin
                cw_keydown <= 1'b0;
                state      <= ST_ELEM_SPACE;
                dur_cnt    <= {2'b0, dot_len};
              end else begin
                dur_cnt <= dur_cnt - 18'd1;
              end
            end
          end
          ST_DASH: begin
            if (set_dot_mem) dot_mem <= 1'b1;
            if (dur_cnt <= 18'd1) begin
              cw_keydown <= 1'b0;
              state      <= ST_ELEM_SPACE;
              dur_cnt    <= {2'b0, dot_len};
            end else begin
              dur_cnt <= dur_cnt - 18'd1;
            end
          end
          ST_ELEM_SPACE: begin
            if (dur_cnt > 18'd1) begin
              dur_cnt <= dur_cnt - 18'd1;
            end else if (!want_any && cfg.spacing) begin
              state   <= ST_LETTER_SPACE;     // two more dot lengths
              dur_cnt <= {1'b0, dot_len, 1'b0};
            end else if (!want_any) begin
              state    <= ST_HANG;
              hang_cnt <= hang_load;
            end
          end
          ST_LETTER_SPACE: begin
            if (dur_cnt > 18'd1) begin
              dur_cnt <= dur_cnt - 18'd1;
            end else if (!want_any) begin
              state    <= ST_HANG;
              hang_cnt <= hang_load;
            end
          end
          ST_HANG: begin
            if (hang_cnt == 16'd0) begin
              cw_ptt <= 1'b0;
              state  <= ST_IDLE;
            end else begin
              hang_cnt <= hang_cnt - 16'd1;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

endmodule

//--- hdl/cw_paddle_input.sv
`timescale 1ns/10ps

module cw_paddle_input import cw_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    tick,
  input  logic    dot_key,
  input  logic    dash_key,
  input  logic    reverse,
  output paddle_t paddles
);

  logic [1:0]      meta;        // bit 0 dot, bit 1 dash
  logic [1:0]      sync;
  logic [1:0]      level;       // debounced contact state
  logic [1:0][3:0] stable_cnt;

  // two-flop synchronizer for the asynchronous contacts
  always_ff @(posedge clk) begin
    meta <= {dash_key, dot_key};
    sync <= meta;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      level      <= 2'b00;
      stable_cnt <= '0;
    end else if (tick) begin
      for (int i = 0; i < 2; i++) begin
        if (sync[i] == level[i]) begin
          stable_cnt[i] <= 4'd0;                  // bounce back, start over
        end else if (stable_cnt[i] == DEBOUNCE_TICKS - 4'd1) begin
          level[i]      <= sync[i];
          stable_cnt[i] <= 4'd0;
        end else begin
          stable_cnt[i] <= stable_cnt[i] + 4'd1;
        end
      end
    end
  end

  assign paddles.dot  = reverse ? level[1] : level[0];  // swap mux
  assign paddles.dash = reverse ? level[0] : level[1];

endmodule

//--- hdl/cw_timing_calc.sv
`timescale 1ns/10ps

module cw_timing_calc import cw_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       recalc,
  input  logic [5:0] speed,
  input  logic [6:0] weight,
  output cw_timing_t timing
);

  logic [29:0] acc;         // remainder window in [29:23], quotient shifts in at bit 0
  logic [5:0]  cnt;
  logic [5:0]  div;
  logic [6:0]  sub;
  logic [29:0] step;
  logic [29:0] product;
  logic [15:0] dot_ticks;
  logic [17:0] dash_ticks;
  logic        valid;

  // first pass divides by speed, second pass by the nominal weight
  assign div = (cnt > CALC_DIV1_LAST) ? WEIGHT_NOMINAL : speed;
  assign sub = acc[29:23] - {1'b0, div};

  // restoring step, a borrow keeps the window and shifts in a 0
  assign step = sub[6] ? {acc[28:0], 1'b0} : {sub[5:0], acc[22:0], 1'b1};

  // the 25th step doubles the quotient, so results are taken from bit 1 up
  assign product = {14'b0, acc[16:1]} * 30'd3 * {23'b0, weight};

  always_ff @(posedge clk) begin
    if (rst || recalc) begin
      cnt   <= 6'd0;                    // restart, also mid-calculation
      acc   <= {14'b0, DOT_NUMERATOR};
      valid <= 1'b0;
    end else if (cnt != CALC_IDLE) begin
      cnt <= cnt + 6'd1;
      if (cnt == CALC_MUL) begin
        acc <= product;                 // dot x 3 x weight
      end else begin
        acc <= step;
      end
      if (cnt == CALC_DIV1_LAST) begin
        dot_ticks <= step[16:1];
      end
      if (cnt == CALC_DIV2_LAST) begin
        dash_ticks <= step[18:1];
        valid      <= 1'b1;             // 52 cycles after recalc
      end
    end
  end

  assign timing.dot_ticks  = dot_ticks;
  assign timing.dash_ticks = dash_ticks;
  assign timing.valid      = valid;

endmodule

//--- hdl/cw_config_regs.sv
`timescale 1ns/10ps

module cw_config_regs import cw_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  cw_cmd_t cmd,
  output cw_cfg_t cfg,
  output logic    recalc
);

  cw_mode_e   mode_dec;
  logic [5:0] speed_dec;

  // 00 straight, 01 mode A, 10 mode B
  always_comb begin
    case (cmd.data[15:14])
      2'b01:   mode_dec = MODE_A;
      2'b10:   mode_dec = MODE_B;
      default: mode_dec = MODE_STRAIGHT;
    endcase
  end

  assign speed_dec = (cmd.data[13:8] == 6'd0) ? 6'd1 : cmd.data[13:8];  // speed 0 runs as 1

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.reverse      <= 1'b0;
      cfg.speed        <= SPEED_DEFAULT;
      cfg.mode         <= MODE_STRAIGHT;
      cfg.weight       <= {1'b0, WEIGHT_NOMINAL};
      cfg.spacing      <= 1'b0;
      cfg.ptt_delay_ms <= 8'd0;
      cfg.hang_ms      <= 10'd0;
      recalc           <= 1'b0;
    end else begin
      recalc <= cmd.rqst && (cmd.addr == ADDR_KEYER);  // speed or weight may change
      if (cmd.rqst) begin
        case (cmd.addr)
          ADDR_KEYER: begin
            cfg.reverse <= cmd.data[22];
            cfg.speed   <= speed_dec;
            cfg.mode    <= mode_dec;
            cfg.weight  <= cmd.data[6:0];
            cfg.spacing <= cmd.data[7];
          end
          ADDR_PTT_DELAY: cfg.ptt_delay_ms <= cmd.data[15:8];
          ADDR_HANG:      cfg.hang_ms <= {cmd.data[31:24], cmd.data[17:16]};
          default: ;  // other addresses belong to other blocks
        endcase
      end
    end
  end

endmodule

//--- hdl/cw_pkg.sv
package cw_pkg;

  // command bus register addresses
  localparam logic [5:0] ADDR_KEYER     = 6'h0b;  // reverse, speed, mode, weight, spacing
  localparam logic [5:0] ADDR_PTT_DELAY = 6'h0f;
  localparam logic [5:0] ADDR_HANG      = 6'h10;

  // keyer tick, 48 kHz in hardware
  localparam int TICK_DIV   = 4;                  // clk cycles per tick
  localparam int TICK_CNT_W = $clog2(TICK_DIV);
  localparam logic [TICK_CNT_W-1:0] TICK_LAST = TICK_CNT_W'(TICK_DIV - 1);

  localparam logic [5:0]  TICKS_PER_MS   = 6'd48;
  localparam logic [15:0] DOT_NUMERATOR  = 16'd57600;  // 1200 ms x 48 ticks
  localparam logic [5:0]  WEIGHT_NOMINAL = 6'd50;      // 50 % weight
  localparam logic [3:0]  DEBOUNCE_TICKS = 4'd2;
  localparam logic [5:0]  SPEED_DEFAULT  = 6'd20;      // wpm after reset

  // timing calculator step counter
  localparam logic [5:0] CALC_DIV1_LAST = 6'd24;  // last dot divide step
  localparam logic [5:0] CALC_MUL       = 6'd25;  // dot x 3 x weight
  localparam logic [5:0] CALC_DIV2_LAST = 6'd50;  // last dash divide step
  localparam logic [5:0] CALC_IDLE      = 6'd51;

  typedef enum logic [1:0] {
    MODE_STRAIGHT,
    MODE_A,
    MODE_B
  } cw_mode_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PTT_WAIT,
    ST_DOT,
    ST_DASH,
    ST_ELEM_SPACE,
    ST_LETTER_SPACE,
    ST_HANG
  } keyer_state_e;

  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
    logic        rqst;  // one-cycle write strobe
  } cw_cmd_t;

  typedef struct packed {
    logic        reverse;       // swap dot and dash paddles
    logic [5:0]  speed;         // wpm, never 0
    cw_mode_e    mode;
    logic [6:0]  weight;
    logic        spacing;       // letter spacing on
    logic [7:0]  ptt_delay_ms;
    logic [9:0]  hang_ms;
  } cw_cfg_t;

  typedef struct packed {
    logic [15:0] dot_ticks;
    logic [17:0] dash_ticks;
    logic        valid;
  } cw_timing_t;

  typedef struct packed {
    logic dot;
    logic dash;
  } paddle_t;

endpackage
